// File: lycan_globals.sv
`default_nettype none

// bridge-wide configuration shared by the RTL and the testbench
package lycan_globals;

  // peripheral fabric
  localparam int num_peripherals = 4;       // loopback units behind the switch
  typedef logic [2:0] periph_addr_t;        // same width as the addr field of a packet

  // ft601 side
  localparam int usb_packet_width = 32;     // one bus word, all four bytes valid

  // queue sizing
  localparam int host_fifo_depth = 16;      // inbound and outbound host queues
  localparam int periph_fifo_depth = 4;     // receive queue inside each peripheral

  // a fifo raises almost_full once its free entries drop to this many or fewer.
  // one entry covers the single word that can still land after the flag is seen
  localparam int almost_full_margin = 1;

endpackage

`default_nettype wire

// File: lycan_packet_pkg.sv
`default_nettype none

// word formats on the host link and the ft601 strobe bundle
package lycan_packet_pkg;

  // command opcodes, anything else is answered with BAD
  typedef enum logic [2:0] {
    ECHO  = 3'd0,  // payload comes straight back
    ACCUM = 3'd1,  // payload added into the 16-bit accumulator
    IDENT = 3'd2   // peripheral reports its own address
  } opcode_t;

  typedef enum logic [1:0] {
    OK  = 2'd0,
    BAD = 2'd1     // unknown opcode, data forced to zero
  } status_t;

  // host -> peripheral
  typedef struct packed {
    lycan_globals::periph_addr_t addr;  // selects the peripheral
    opcode_t                     opcode;
    logic [9:0]                  reserved;
    logic [15:0]                 payload;
  } cmd_word_t;

  // peripheral -> host
  typedef struct packed {
    lycan_globals::periph_addr_t addr;  // source peripheral
    status_t                     status;
    logic [10:0]                 reserved;
    logic [15:0]                 data;
  } rsp_word_t;

  // one 32-bit word, read as a command inbound and as a response outbound
  typedef union packed {
    cmd_word_t cmd;
    rsp_word_t rsp;
  } lycan_word_u;

  // active-low ft601 pins owned by the controller
  typedef struct packed {
    logic wren_l;
    logic rden_l;
    logic outen_l;
    logic usb_rst_l;
  } ft601_bus_t;

endpackage

`default_nettype wire

// File: sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = lycan_globals::usb_packet_width,
  parameter int DEPTH = lycan_globals::host_fifo_depth
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push,
  input  wire logic             pop,
  input  wire logic [WIDTH-1:0] din,
  output logic      [WIDTH-1:0] dout,   // head word, valid whenever empty is low
  output logic                  empty,
  output logic                  full,
  output logic                  almost_full
);

  import lycan_globals::*;

  logic [WIDTH-1:0]             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;   // 0..DEPTH entries

  // storage, no reset on the data array
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;  // wrap at depth
      if (pop)  rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                        // idle or push+pop, level unchanged
      endcase
    end
  end

  assign dout        = mem[rd_ptr];      // show-ahead, head visible the cycle after push
  assign empty       = (count == '0);
  assign full        = (int'(count) == DEPTH);
  assign almost_full = (DEPTH - int'(count)) <= almost_full_margin;

  // producers and consumers must honour the flags
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

// File: ft601_controller.sv
`default_nettype none

module ft601_controller (
  input  wire logic                   clk,            // ft601 clock
  input  wire logic                   rst_n,
  input  wire logic                   usb_tx_full,    // 1 = host cannot take a word
  input  wire logic                   usb_rx_empty,   // 0 = host has a word for us
  output lycan_packet_pkg::ft601_bus_t bus,
  output logic                        usb_data_oe,    // we own usb_data
  output logic                        in_push,        // host word -> inbound fifo
  input  wire logic                   in_almost_full,
  input  wire logic                   out_empty,
  output logic                        out_pop         // outbound head -> usb_data_out
);

  typedef enum logic [1:0] {
    IDLE,   // bus released, pick a direction
    TURN,   // outen_l low for one cycle before rden_l
    READ,   // host drives data, one word per cycle while rx not empty
    WRITE   // we drive data, one word per cycle while tx not full
  } state_t;

  state_t state;
  state_t state_d;
  logic   usb_rst_q;   // held low through reset, high after
  logic   rd_xfer;
  logic   wr_xfer;

  assign rd_xfer = (state == READ) && !usb_rx_empty;
  assign wr_xfer = (state == WRITE) && !out_empty && !usb_tx_full;

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        // a pending read wins, but only from idle
        if (!usb_rx_empty && !in_almost_full) state_d = TURN;
        else if (!out_empty && !usb_tx_full) state_d = WRITE;
      end
      TURN:  state_d = READ;
      READ: begin
        if (usb_rx_empty || in_almost_full) state_d = IDLE;  // drops rden_l and outen_l at once
      end
      WRITE: begin
        if (out_empty || usb_tx_full) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      usb_rst_q <= 1'b0;
    end else begin
      state     <= state_d;
      usb_rst_q <= 1'b1;                  // release the chip once we are out of reset
    end
  end

  // strobes decode straight from state, wren_l also follows the live flags
  always_comb begin
    bus.wren_l    = !wr_xfer;
    bus.rden_l    = (state != READ);
    bus.outen_l   = !((state == TURN) || (state == READ));
    bus.usb_rst_l = usb_rst_q;
  end

  assign usb_data_oe = (state == WRITE);
  assign in_push     = rd_xfer;           // every rden_l & rx_empty low cycle carries a word
  assign out_pop     = wr_xfer;           // every wren_l low cycle consumes the head

  // one direction at a time on the shared data bus
  a_rd_wr_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(!bus.rden_l && !bus.wren_l));

  // rden_l only falls after a turnaround cycle with outen_l already low
  a_turnaround : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(bus.rden_l) |-> $past(!bus.outen_l));

endmodule

`default_nettype wire

// File: periph_loopback.sv
`default_nettype none

module periph_loopback (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire lycan_globals::periph_addr_t  self_addr,        // tag for every response
  input  wire logic                         cmd_valid,        // command is for us this cycle
  input  wire lycan_packet_pkg::cmd_word_t  cmd,
  input  wire logic                         rsp_pop,
  output lycan_packet_pkg::rsp_word_t       rsp_head,
  output logic                              rsp_empty,
  output logic                              rsp_almost_full
);

  import lycan_globals::*;
  import lycan_packet_pkg::*;

  logic [15:0] acc;        // running ACCUM total
  logic [15:0] acc_sum;    // total after this payload, wraps mod 2^16
  rsp_word_t   rsp_d;
  rsp_word_t   rsp_q;      // response staged for the receive fifo
  logic        push_q;

  assign acc_sum = acc + cmd.payload;

  // response for the command currently presented
  always_comb begin
    rsp_d        = '0;
    rsp_d.addr   = self_addr;
    rsp_d.status = OK;
    case (cmd.opcode)
      ECHO:    rsp_d.data = cmd.payload;
      ACCUM:   rsp_d.data = acc_sum;          // new sum, not the old one
      IDENT:   rsp_d.data = 16'(self_addr);   // address in the low bits
      default: begin
        rsp_d.status = BAD;
        rsp_d.data   = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc    <= '0;
      push_q <= 1'b0;
    end else begin
      push_q <= cmd_valid;                    // fifo write one cycle after the command
      if (cmd_valid && (cmd.opcode == ACCUM)) acc <= acc_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) rsp_q <= rsp_d;
  end

  // receive queue, almost_full leaves room for the word staged in rsp_q
  sync_fifo #(
    .WIDTH ($bits(rsp_word_t)),
    .DEPTH (periph_fifo_depth)
  ) u_rsp_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (push_q),
    .pop         (rsp_pop),
    .din         (rsp_q),
    .dout        (rsp_head),
    .empty       (rsp_empty),
    .full        (),
    .almost_full (rsp_almost_full)
  );

endmodule

`default_nettype wire

// File: periph_switch.sv
`default_nettype none

module periph_switch (
  input  wire logic                                                          clk,
  input  wire logic                                                          rst_n,
  input  wire lycan_packet_pkg::lycan_word_u                                 in_head,
  input  wire logic                                                          in_empty,
  output logic                                                               in_pop,
  output logic [lycan_globals::num_peripherals-1:0]                          cmd_valid,
  input  wire lycan_packet_pkg::rsp_word_t [lycan_globals::num_peripherals-1:0] rsp_heads,
  input  wire logic [lycan_globals::num_peripherals-1:0]                     rsp_empty,
  input  wire logic [lycan_globals::num_peripherals-1:0]                     rsp_almost_full,
  output logic [lycan_globals::num_peripherals-1:0]                          rsp_pop,
  output logic                                                               out_push,
  output lycan_packet_pkg::lycan_word_u                                      out_word,
  input  wire logic                                                          out_full
);

  import lycan_globals::*;
  import lycan_packet_pkg::*;

  periph_addr_t               head_addr;
  logic                       head_blocked;  // target queue near full, hold the line
  logic [num_peripherals-1:0] rsp_urgent;
  logic [num_peripherals-1:0] pool;          // candidates for this grant
  periph_addr_t               rr_ptr;        // first peripheral to look at
  periph_addr_t               grant_idx;
  logic                       grant_valid;

  assign head_addr = in_head.cmd.addr;

  // address decode, an address past the last peripheral matches nothing and is dropped
  always_comb begin
    cmd_valid    = '0;
    head_blocked = 1'b0;
    for (int i = 0; i < num_peripherals; i++) begin
      if (head_addr == periph_addr_t'(i)) begin
        head_blocked = rsp_almost_full[i];
        cmd_valid[i] = !in_empty && !rsp_almost_full[i];
      end
    end
  end

  assign in_pop = !in_empty && !head_blocked;   // same cycle as cmd_valid

  // round robin from rr_ptr, queues close to full are served first
  always_comb begin
    int idx;
    rsp_urgent  = ~rsp_empty & rsp_almost_full;
    pool        = (|rsp_urgent) ? rsp_urgent : ~rsp_empty;
    grant_valid = 1'b0;
    grant_idx   = rr_ptr;
    for (int k = num_peripherals - 1; k >= 0; k--) begin   // downward so offset 0 wins
      idx = (int'(rr_ptr) + k) % num_peripherals;
      if (pool[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = periph_addr_t'(idx);
      end
    end
  end

  always_comb begin
    rsp_pop = '0;
    for (int i = 0; i < num_peripherals; i++) begin
      rsp_pop[i] = grant_valid && !out_full && (grant_idx == periph_addr_t'(i));
    end
  end

  // popped head goes into the outbound fifo, visible there next cycle
  assign out_push     = |rsp_pop;
  assign out_word.rsp = rsp_heads[grant_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (out_push) begin
      rr_ptr <= (int'(grant_idx) == num_peripherals - 1) ? '0 : grant_idx + 1'b1;
    end
  end

  // one peripheral per cycle in each direction
  a_cmd_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cmd_valid));
  a_pop_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rsp_pop));

endmodule

`default_nettype wire

// File: lycan.sv
`default_nettype none

module lycan (
  input  wire logic                                  clk,            // ft601 clock
  input  wire logic                                  rst_n,
  input  wire logic                                  usb_tx_full,    // 0 = space available
  input  wire logic                                  usb_rx_empty,   // 0 = data available
  input  wire logic [lycan_globals::usb_packet_width-1:0] usb_data_in,
  output logic      [lycan_globals::usb_packet_width-1:0] usb_data_out,
  output logic                                       usb_data_oe,    // 1 = drive usb_data
  output logic                                       usb_wren_l,
  output logic                                       usb_rden_l,
  output logic                                       usb_outen_l,
  output logic                                       usb_rst_l
);

  import lycan_globals::*;
  import lycan_packet_pkg::*;

  ft601_bus_t                  bus;
  logic                        in_push;
  logic                        in_pop;
  logic                        in_empty;
  logic                        in_almost_full;
  lycan_word_u                 in_head;          // next command for the switch
  logic                        out_push;
  logic                        out_pop;
  logic                        out_empty;
  logic                        out_full;
  lycan_word_u                 out_word;         // granted response
  logic [num_peripherals-1:0]  cmd_valid;
  logic [num_peripherals-1:0]  rsp_pop;
  logic [num_peripherals-1:0]  rsp_empty;
  logic [num_peripherals-1:0]  rsp_almost_full;
  rsp_word_t [num_peripherals-1:0] rsp_heads;

  ft601_controller u_ft601 (
    .clk            (clk),
    .rst_n          (rst_n),
    .usb_tx_full    (usb_tx_full),
    .usb_rx_empty   (usb_rx_empty),
    .bus            (bus),
    .usb_data_oe    (usb_data_oe),
    .in_push        (in_push),
    .in_almost_full (in_almost_full),
    .out_empty      (out_empty),
    .out_pop        (out_pop)
  );

  assign usb_wren_l  = bus.wren_l;
  assign usb_rden_l  = bus.rden_l;
  assign usb_outen_l = bus.outen_l;
  assign usb_rst_l   = bus.usb_rst_l;

  // host -> bridge
  sync_fifo #(.WIDTH($bits(lycan_word_u)), .DEPTH(host_fifo_depth)) u_in_fifo (
    .clk (clk), .rst_n (rst_n), .push (in_push), .pop (in_pop), .din (usb_data_in),
    .dout (in_head), .empty (in_empty), .full (), .almost_full (in_almost_full)
  );

  // bridge -> host
  sync_fifo #(.WIDTH($bits(lycan_word_u)), .DEPTH(host_fifo_depth)) u_out_fifo (
    .clk (clk), .rst_n (rst_n), .push (out_push), .pop (out_pop), .din (out_word),
    .dout (usb_data_out), .empty (out_empty), .full (out_full), .almost_full ()
  );

  periph_switch u_switch (
    .clk (clk), .rst_n (rst_n),
    .in_head (in_head), .in_empty (in_empty), .in_pop (in_pop), .cmd_valid (cmd_valid),
    .rsp_heads (rsp_heads), .rsp_empty (rsp_empty), .rsp_almost_full (rsp_almost_full),
    .rsp_pop (rsp_pop), .out_push (out_push), .out_word (out_word), .out_full (out_full)
  );

  // every peripheral sees the same head command, cmd_valid picks the one that acts
  for (genvar i = 0; i < num_peripherals; i++) begin : gen_periph
    periph_loopback u_periph (
      .clk (clk), .rst_n (rst_n), .self_addr (periph_addr_t'(i)),
      .cmd_valid (cmd_valid[i]), .cmd (in_head.cmd), .rsp_pop (rsp_pop[i]),
      .rsp_head (rsp_heads[i]), .rsp_empty (rsp_empty[i]),
      .rsp_almost_full (rsp_almost_full[i])
    );
  end

endmodule

`default_nettype wire

// File: tb_lycan.sv
`default_nettype none

module tb_lycan;

  timeunit 1ns;
  timeprecision 100ps;

  import lycan_globals::*;
  import lycan_packet_pkg::*;

  logic                        clk;
  logic                        rst_n;
  logic                        usb_tx_full;
  logic                        usb_rx_empty;
  logic [usb_packet_width-1:0] usb_data_in;
  logic [usb_packet_width-1:0] usb_data_out;
  logic                        usb_data_oe;
  logic                        usb_wren_l;
  logic                        usb_rden_l;
  logic                        usb_outen_l;
  logic                        usb_rst_l;

  logic [31:0] host_q[$];         // words the host still has for the bridge
  logic [31:0] pending[$];        // expected responses, oldest first across all addresses
  logic [31:0] cmd_all[$];        // every command from the stimulus file
  logic [31:0] exp_all[$];        // matching expected words, ffffffff = no response
  logic [3:0]  stall_pat [1024];  // [1:0] zero holds rx_empty, [3] set holds tx_full
  bit          stall_en;
  int          cycle_cnt;
  int          errors;
  int          checks;

  lycan u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .usb_tx_full  (usb_tx_full),
    .usb_rx_empty (usb_rx_empty),
    .usb_data_in  (usb_data_in),
    .usb_data_out (usb_data_out),
    .usb_data_oe  (usb_data_oe),
    .usb_wren_l   (usb_wren_l),
    .usb_rden_l   (usb_rden_l),
    .usb_outen_l  (usb_outen_l),
    .usb_rst_l    (usb_rst_l)
  );

  always #5 clk = ~clk;  // 100 MHz

  // ft601 host side, one word leaves on every rden_l low cycle with data present
  always @(posedge clk) begin : host_model
    logic [3:0] pat;
    pat = stall_pat[cycle_cnt[9:0]];
    cycle_cnt = cycle_cnt + 1;
    if (!usb_rden_l && !usb_rx_empty && host_q.size() != 0) void'(host_q.pop_front());
    if (host_q.size() != 0 && !(stall_en && pat[1:0] == 2'd0)) begin
      usb_rx_empty <= 1'b0;
      usb_data_in  <= host_q[0];
    end else begin
      usb_rx_empty <= 1'b1;   // nothing to send, or a random gap
    end
    usb_tx_full <= stall_en && pat[3];
  end

  // every wren_l low cycle hands one response to the host
  always @(posedge clk) begin : bus_monitor
    if (rst_n && !usb_wren_l) begin
      checks++;
      assert (usb_data_oe) else begin
        $display("ERROR: %0d ns: wren_l low while usb_data_oe is low", $time);
        errors++;
      end
      check_response(usb_data_out);
    end
  end

  task automatic build_stall_table();
    void'($urandom(32'h860c_2abb));  // seeds this run
    for (int i = 0; i < 1024; i++) stall_pat[i] = 4'($urandom);
  endtask

  task automatic check_idle(input logic rst_l_exp);
    checks++;
    assert (usb_wren_l && usb_rden_l && usb_outen_l && !usb_data_oe && usb_rst_l === rst_l_exp)
      else begin
        $display("ERROR: %0d ns: bus not idle, wren_l %b rden_l %b outen_l %b oe %b rst_l %b",
                 $time, usb_wren_l, usb_rden_l, usb_outen_l, usb_data_oe, usb_rst_l);
        errors++;
      end
  endtask

  // match against the oldest expected word with the same address
  task automatic check_response(input logic [31:0] word);
    rsp_word_t r;
    int        idx;
    r   = word;
    idx = -1;
    for (int k = 0; k < pending.size(); k++) begin
      if (idx < 0 && pending[k][31:29] == r.addr) idx = k;
    end
    checks++;
    assert (idx >= 0) else begin
      $display("%0d ns: response %h from address %0d arrived with no command waiting for it",
               $time, word, r.addr);
      errors++;
    end
    if (idx >= 0) begin
      assert (word === pending[idx]) else begin
        $display("ERROR: %0d ns: address %0d returned %h, expected %h",
                 $time, r.addr, word, pending[idx]);
        errors++;
      end
      pending.delete(idx);
    end
  endtask

  task automatic run_block(input string name, input int first, input int count,
                           input bit stall, output bit timed_out);
    int cycles;
    int errs_before;
    errs_before = errors;
    stall_en    = stall;
    for (int j = first; j < first + count; j++) begin
      if (exp_all[j] != 32'hffff_ffff) pending.push_back(exp_all[j]);
      host_q.push_back(cmd_all[j]);
    end
    cycles = 0;
    while ((host_q.size() != 0 || pending.size() != 0) && cycles < 4000) begin
      @(negedge clk);
      cycles++;
    end
    timed_out = (host_q.size() != 0 || pending.size() != 0);
    stall_en  = 1'b0;
    if (timed_out) begin
      $display("timeout in block %s: %0d words not read, %0d responses missing",
               name, host_q.size(), pending.size());
    end else begin
      cycles = 0;
      while (cycles < 30) begin  // quiet window so a stray word gets caught here
        @(negedge clk);
        cycles++;
      end
    end
    $display("test %s: %0d commands, %0d errors", name, count, errors - errs_before);
  endtask

  initial begin
    int          fd;
    int          n;
    int          tstall;
    int          last;
    string       line;
    string       tname;
    string       names[$];
    int          stalls[$];
    int          firsts[$];
    logic [31:0] w [8];
    bit          timed_out;
    clk          = 1'b0;
    rst_n        = 1'b0;
    usb_tx_full  = 1'b0;
    usb_rx_empty = 1'b1;
    usb_data_in  = '0;
    stall_en     = 1'b0;
    cycle_cnt    = 0;
    errors       = 0;
    checks       = 0;
    timed_out    = 1'b0;
    build_stall_table();

    fd = $fopen("lycan_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open lycan_stimulus.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;
        if (line.substr(0, 3) == "test") begin
          n = $sscanf(line, "test %s %d", tname, tstall);
          names.push_back(tname);
          stalls.push_back(tstall);
          firsts.push_back(cmd_all.size());
        end else begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h", w[0], w[1], w[2], w[3],
                      w[4], w[5], w[6], w[7]);
          for (int k = 0; k + 1 < n; k += 2) begin
            cmd_all.push_back(w[k]);
            exp_all.push_back(w[k+1]);
          end
        end
      end
      $fclose(fd);
    end

    // reset for 10 cycles, outputs checked inside and just after it
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_idle(1'b0);
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(negedge clk);
    check_idle(1'b1);
    $display("test reset_idle: 2 checks, %0d errors", errors);

    for (int t = 0; t < names.size() && !timed_out; t++) begin
      last = (t + 1 < names.size()) ? firsts[t+1] : cmd_all.size();
      run_block(names[t], firsts[t], last - firsts[t], stalls[t] != 0, timed_out);
    end

    $display("%0d tests, %0d checks, %0d errors", names.size() + 1, checks, errors);
    if (errors == 0 && !timed_out && names.size() != 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: lycan_stimulus.txt
# test <name> <stall 0|1>, then lines of up to four pairs: command word, expected response
# an expected word of ffffffff means the command must draw no response
test echo_all 0
00001234 00001234 20005678 20005678 4000abcd 4000abcd 6000ffff 6000ffff
test accum_run 0
24000010 20000010 24000020 20000030 44000005 40000005 2400fff0 20000020
64000007 60000007 24000001 20000021 44000100 40000105 04000002 00000002
test ident_bad 0
0800beef 00000000 28000000 20000001 48000000 40000002 68000000 60000003
14001234 08000000 3c00ffff 28000000 4c000011 48000000 7000aaaa 68000000
test drop_addr 0
80001111 ffffffff 00002222 00002222 e4000005 ffffffff 24000003 20000024
a0000000 ffffffff 68000000 60000003 c8000000 ffffffff 40004444 40004444
test burst_stall 1
00000101 00000101 24000004 20000028 48000000 40000002 6400000a 60000011
04000010 00000012 2000beef 2000beef 44000001 40000106 60000202 60000202
08000000 00000000 28000000 20000001 40000303 40000303 64000100 60000111
04000100 00000112 24000008 20000030 4400ff00 40000006 68000000 60000003
20000001 20000001 20000002 20000002 20000003 20000003 20000004 20000004
24000001 20000031 24000001 20000032 24000001 20000033 14000000 08000000
00000404 00000404 40000505 40000505 60000606 60000606 3c000000 28000000
04000001 00000113 44000002 40000008 64000003 60000114 24000004 20000037
48000000 40000002 00007777 00007777 2000abcd 2000abcd 6000dcba 6000dcba
0400fffe 00000111 24000009 20000040 44000010 40000018 6400ffff 60000113

// File: compile.f
lycan_globals.sv
lycan_packet_pkg.sv
sync_fifo.sv
ft601_controller.sv
periph_loopback.sv
periph_switch.sv
lycan.sv
tb_lycan.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_lycan with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lycan \
		-f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_lycan)"; echo "$$out"; \
		echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
